// File: scpad_cfg.svh
`ifndef SCPAD_CFG_SVH
`define SCPAD_CFG_SVH

// scratchpad geometry
`define SCPAD_BANKS 4
`define WORD_W      32
`define SLOT_W      8
`define BANK_W      ($clog2(`SCPAD_BANKS))

// tile limits, height in rows, width bounded by bank count
`define MAX_ROWS    8
`define DIM_W       ($clog2(`MAX_ROWS) + 1)

// dram side
`define DRAM_ADDR_W 32
`define ROW_BYTES   16
`define NBYTES_W    ($clog2(`ROW_BYTES) + 1)

// 16 ids, well above rows in flight
`define DRAM_ID_W   4
`define ID_COUNT    (1 << `DRAM_ID_W)

// outgoing read request fifo
`define Q_DEPTH     4

`endif

// File: scpad_pkg.sv
`include "scpad_cfg.svh"

package scpad_pkg;

    // plain vectors
    typedef logic [`WORD_W-1:0]      word_t;
    typedef word_t [`SCPAD_BANKS-1:0] row_data_t;
    typedef logic [`DRAM_ADDR_W-1:0] dram_addr_t;
    typedef logic [`SLOT_W-1:0]      slot_t;
    typedef logic [`DRAM_ID_W-1:0]   dram_id_t;
    typedef logic [`DIM_W-1:0]       dim_t;
    typedef logic [`SCPAD_BANKS-1:0] lane_mask_t;
    typedef logic [`BANK_W-1:0]      bank_t;
    typedef logic [`NBYTES_W-1:0]    nbytes_t;

    // tile load request from the scheduler
    typedef struct packed {
        dram_addr_t dram_addr;
        slot_t      spad_addr;
        dim_t       num_rows;
        dim_t       num_cols;
        // 0 = row orientation
        logic       row_or_col;
    } sched_req_t;

    typedef struct packed {
        slot_t spad_addr;
        dim_t  num_rows;
    } sched_rsp_t;

    // crossbar descriptor for one row write
    typedef struct packed {
        slot_t      slot;
        bank_t      shift;
        logic       col_mode;
        lane_mask_t lane_mask;
    } xbar_desc_t;

    typedef struct packed {
        dram_id_t   id;
        dram_addr_t dram_addr;
        nbytes_t    num_bytes;
    } dram_req_t;

    typedef struct packed {
        dram_id_t  id;
        row_data_t row_data;
    } dram_rsp_t;

    typedef struct packed {
        xbar_desc_t xbar_desc;
        row_data_t  row_data;
    } scpad_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN,
        RESPOND
    } ctrl_state_t;

endpackage

// File: backend_ctrl.sv
`timescale 1ns/1ps

module backend_ctrl
    import scpad_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       sched_req_valid,
    input  sched_req_t sched_req,
    output logic       sched_req_ready,
    output logic       sched_rsp_valid,
    output sched_rsp_t sched_rsp,
    input  logic       sched_rsp_ready,
    input  logic       queue_full,
    input  logic       row_done,
    output logic       issue,
    output dram_id_t   uuid,
    output dim_t       row_idx,
    output sched_req_t cur_req
);

    ctrl_state_t state;
    ctrl_state_t nxt_state;
    dim_t        issued_cnt;
    dim_t        done_cnt;
    logic        req_accept;
    logic        last_issue;
    logic        last_done;

    // one tile at a time so ready only in idle
    assign sched_req_ready = (state == IDLE);
    assign req_accept      = sched_req_valid && sched_req_ready;

    // queue full is the only stall
    assign issue   = (state == ISSUE) && !queue_full;
    assign row_idx = issued_cnt;

    assign last_issue = issue && (issued_cnt == cur_req.num_rows - dim_t'(1));
    // look ahead on row_done so the response goes out the next cycle
    assign last_done  = (done_cnt == cur_req.num_rows) ||
                        (row_done && (done_cnt + dim_t'(1) == cur_req.num_rows));

    assign sched_rsp_valid     = (state == RESPOND);
    assign sched_rsp.spad_addr = cur_req.spad_addr;
    assign sched_rsp.num_rows  = cur_req.num_rows;

    always_comb begin
        nxt_state = state;
        case (state)
            IDLE:    if (req_accept) nxt_state = ISSUE;
            ISSUE:   if (last_issue) nxt_state = DRAIN;
            DRAIN:   if (last_done) nxt_state = RESPOND;
            RESPOND: if (sched_rsp_ready) nxt_state = IDLE;
            default: nxt_state = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state      <= IDLE;
            issued_cnt <= '0;
            done_cnt   <= '0;
            uuid       <= '0;
        end else begin
            state <= nxt_state;
            if (req_accept) begin
                issued_cnt <= '0;
                done_cnt   <= '0;
            end else begin
                // issue and completion counted apart so rows overlap
                if (issue) issued_cnt <= issued_cnt + dim_t'(1);
                if (row_done) done_cnt <= done_cnt + dim_t'(1);
            end
            // uuid keeps running across tiles and wraps at 16
            if (issue) uuid <= uuid + dram_id_t'(1);
        end
    end

    // latched tile request
    always_ff @(posedge clk) begin
        if (req_accept) cur_req <= sched_req;
    end

    // write path never retires a row that was not issued
    a_done_le_issued: assert property (
        @(posedge clk) disable iff (!n_rst) done_cnt <= issued_cnt);

    // write path must not report more rows than were asked for
    a_done_bounded: assert property (
        @(posedge clk) disable iff (!n_rst)
        (state != IDLE) |-> (done_cnt <= cur_req.num_rows));

endmodule

// File: addr_map.sv
`timescale 1ns/1ps
`include "scpad_cfg.svh"

module addr_map
    import scpad_pkg::*;
(
    input  sched_req_t cur_req,
    input  dim_t       row_idx,
    input  dram_id_t   uuid,
    output dram_req_t  dram_req,
    output xbar_desc_t xbar_desc
);

    dram_addr_t row_offset;
    lane_mask_t mask;

    // one dram beat per row, rows packed back to back
    assign row_offset = dram_addr_t'(row_idx) * dram_addr_t'(`ROW_BYTES);

    assign dram_req.id        = uuid;
    assign dram_req.dram_addr = cur_req.dram_addr + row_offset;
    // 4 bytes per word
    assign dram_req.num_bytes = nbytes_t'(cur_req.num_cols) << 2;

    // low num_cols lanes carry data
    always_comb begin
        for (int k = 0; k < `SCPAD_BANKS; k++) begin
            mask[k] = (k < int'(cur_req.num_cols));
        end
    end

    // swizzle policy
    // row r lands at base slot + r
    assign xbar_desc.slot      = cur_req.spad_addr + slot_t'(row_idx);
    // bank rotation by r mod 4 so consecutive rows start on different banks
    assign xbar_desc.shift     = bank_t'(row_idx);
    // scratchpad side decides the transpose from this flag
    assign xbar_desc.col_mode  = cur_req.row_or_col;
    assign xbar_desc.lane_mask = mask;

endmodule

// File: dram_read_req_queue.sv
`timescale 1ns/1ps
`include "scpad_cfg.svh"

module dram_read_req_queue
    import scpad_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,
    input  logic      push,
    input  dram_req_t push_req,
    output logic      full,
    output logic      be_dram_req_valid,
    output dram_req_t be_dram_req,
    input  logic      be_dram_req_ready
);

    dram_req_t                      mem [`Q_DEPTH];
    logic [$clog2(`Q_DEPTH)-1:0]    wr_ptr;
    logic [$clog2(`Q_DEPTH)-1:0]    rd_ptr;
    logic [$clog2(`Q_DEPTH+1)-1:0]  count;
    logic                           pop;

    assign full              = (count == ($clog2(`Q_DEPTH+1))'(`Q_DEPTH));
    assign be_dram_req_valid = (count != '0);
    // head entry, stable until dram takes it
    assign be_dram_req       = mem[rd_ptr];
    assign pop               = be_dram_req_valid && be_dram_req_ready;

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_req;
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!n_rst) !(push && full));

    // dram valid/ready rule, request held until taken
    a_req_held: assert property (
        @(posedge clk) disable iff (!n_rst)
        (be_dram_req_valid && !be_dram_req_ready) |=>
            (be_dram_req_valid && $stable(be_dram_req)));

endmodule

// File: scpad_write_path.sv
`timescale 1ns/1ps
`include "scpad_cfg.svh"

module scpad_write_path
    import scpad_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       wr_en,
    input  dram_id_t   wr_id,
    input  xbar_desc_t wr_desc,
    input  logic       dram_be_res_valid,
    input  dram_rsp_t  dram_be_res,
    output logic       dram_be_res_ready,
    output logic       scpad_wr_valid,
    output scpad_wr_t  scpad_wr,
    input  logic       scpad_wr_ready,
    output logic       row_done
);

    // in-flight table, one descriptor per id
    xbar_desc_t            desc_tbl [`ID_COUNT];
    logic [`ID_COUNT-1:0]  tbl_valid;
    logic                  wr_xfer;

    // responses pass straight through to the scratchpad
    assign scpad_wr_valid     = dram_be_res_valid;
    assign scpad_wr.xbar_desc = desc_tbl[dram_be_res.id];
    assign scpad_wr.row_data  = dram_be_res.row_data;

    // scratchpad stall backs up into dram
    assign dram_be_res_ready = scpad_wr_ready;

    assign wr_xfer  = scpad_wr_valid && scpad_wr_ready;
    assign row_done = wr_xfer;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            tbl_valid <= '0;
        end else begin
            // retire first, a new entry on the same id wins
            if (wr_xfer) tbl_valid[dram_be_res.id] <= 1'b0;
            if (wr_en) tbl_valid[wr_id] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) desc_tbl[wr_id] <= wr_desc;
    end

    // dram only answers ids that were issued and not yet retired
    a_rsp_id_known: assert property (
        @(posedge clk) disable iff (!n_rst)
        dram_be_res_valid |-> tbl_valid[dram_be_res.id]);

    // uuid wrap must not overrun a row still in flight
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (!n_rst)
        wr_en |-> !tbl_valid[wr_id]);

endmodule

// File: backend.sv
`timescale 1ns/1ps

module backend
    import scpad_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    // scheduler
    input  logic       sched_req_valid,
    output logic       sched_req_ready,
    input  sched_req_t sched_req,
    output logic       sched_rsp_valid,
    input  logic       sched_rsp_ready,
    output sched_rsp_t sched_rsp,
    // dram
    output logic       be_dram_req_valid,
    input  logic       be_dram_req_ready,
    output dram_req_t  be_dram_req,
    input  logic       dram_be_res_valid,
    output logic       dram_be_res_ready,
    input  dram_rsp_t  dram_be_res,
    // scratchpad
    output logic       scpad_wr_valid,
    input  logic       scpad_wr_ready,
    output scpad_wr_t  scpad_wr
);

    logic       issue;
    logic       queue_full;
    logic       row_done;
    dram_id_t   uuid;
    dim_t       row_idx;
    sched_req_t cur_req;
    dram_req_t  row_req;
    xbar_desc_t row_desc;

    backend_ctrl u_ctrl (
        .clk             (clk),
        .n_rst           (n_rst),
        .sched_req_valid (sched_req_valid),
        .sched_req       (sched_req),
        .sched_req_ready (sched_req_ready),
        .sched_rsp_valid (sched_rsp_valid),
        .sched_rsp       (sched_rsp),
        .sched_rsp_ready (sched_rsp_ready),
        .queue_full      (queue_full),
        .row_done        (row_done),
        .issue           (issue),
        .uuid            (uuid),
        .row_idx         (row_idx),
        .cur_req         (cur_req)
    );

    // per-row address and swizzle
    addr_map u_addr_map (
        .cur_req   (cur_req),
        .row_idx   (row_idx),
        .uuid      (uuid),
        .dram_req  (row_req),
        .xbar_desc (row_desc)
    );

    dram_read_req_queue u_rd_req_q (
        .clk               (clk),
        .n_rst             (n_rst),
        .push              (issue),
        .push_req          (row_req),
        .full              (queue_full),
        .be_dram_req_valid (be_dram_req_valid),
        .be_dram_req       (be_dram_req),
        .be_dram_req_ready (be_dram_req_ready)
    );

    // descriptor parked at uuid in the same cycle as the push
    scpad_write_path u_wr_path (
        .clk               (clk),
        .n_rst             (n_rst),
        .wr_en             (issue),
        .wr_id             (uuid),
        .wr_desc           (row_desc),
        .dram_be_res_valid (dram_be_res_valid),
        .dram_be_res       (dram_be_res),
        .dram_be_res_ready (dram_be_res_ready),
        .scpad_wr_valid    (scpad_wr_valid),
        .scpad_wr          (scpad_wr),
        .scpad_wr_ready    (scpad_wr_ready),
        .row_done          (row_done)
    );

endmodule

// File: backend_tb.sv
`timescale 1ns/1ps
`include "scpad_cfg.svh"

module backend_tb
    import scpad_pkg::*;
();

    localparam int unsigned NUM_TILES   = 40;
    // worst case budget per row, all rows of all tiles
    localparam int unsigned TIMEOUT_CYC = NUM_TILES * `MAX_ROWS * 60;

    // one read accepted by the dram model, waiting to be answered
    typedef struct packed {
        dram_id_t    id;
        dram_addr_t  addr;
        xbar_desc_t  desc;
        logic [31:0] due;
    } pend_t;

    logic       clk;
    logic       n_rst;
    logic       sched_req_valid;
    logic       sched_req_ready;
    sched_req_t sched_req;
    logic       sched_rsp_valid;
    logic       sched_rsp_ready;
    sched_rsp_t sched_rsp;
    logic       be_dram_req_valid;
    logic       be_dram_req_ready;
    dram_req_t  be_dram_req;
    logic       dram_be_res_valid;
    logic       dram_be_res_ready;
    dram_rsp_t  dram_be_res;
    logic       scpad_wr_valid;
    logic       scpad_wr_ready;
    scpad_wr_t  scpad_wr;

    // reference model, rows in issue order
    dram_req_t   exp_req_q [$];
    xbar_desc_t  exp_desc_q [$];
    pend_t       pend_q [$];
    int unsigned cycles;
    int unsigned err_cnt;
    int unsigned chk_cnt;
    int unsigned tile_wr_cnt;
    dram_id_t    model_uuid;

    backend DUT (
        .clk               (clk),
        .n_rst             (n_rst),
        .sched_req_valid   (sched_req_valid),
        .sched_req_ready   (sched_req_ready),
        .sched_req         (sched_req),
        .sched_rsp_valid   (sched_rsp_valid),
        .sched_rsp_ready   (sched_rsp_ready),
        .sched_rsp         (sched_rsp),
        .be_dram_req_valid (be_dram_req_valid),
        .be_dram_req_ready (be_dram_req_ready),
        .be_dram_req       (be_dram_req),
        .dram_be_res_valid (dram_be_res_valid),
        .dram_be_res_ready (dram_be_res_ready),
        .dram_be_res       (dram_be_res),
        .scpad_wr_valid    (scpad_wr_valid),
        .scpad_wr_ready    (scpad_wr_ready),
        .scpad_wr          (scpad_wr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYC) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("test failed");
        $finish;
    end

    // dram contents, hash over the full byte address
    function automatic word_t mem_word(dram_addr_t addr);
        word_t h;
        h = addr * 32'h9e37_79b9;
        h = h ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
        return h;
    endfunction

    // word k of a beat sits at addr + 4k
    function automatic row_data_t dram_row(dram_addr_t addr);
        row_data_t row;
        for (int k = 0; k < `SCPAD_BANKS; k++) begin
            row[k] = mem_word(addr + dram_addr_t'(4 * k));
        end
        return row;
    endfunction

    task automatic report_fault(input string text);
        err_cnt++;
        $display("%s", text);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_req(input dram_req_t got, input dram_req_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] be_dram_req got %h expected %h", got, exp);
        end
    endtask

    task automatic check_wr(input scpad_wr_t got, input scpad_wr_t exp);
        chk_cnt++;
        if (got.xbar_desc !== exp.xbar_desc) begin
            err_cnt++;
            $display("[ERROR] scpad_wr.xbar_desc got %h expected %h",
                     got.xbar_desc, exp.xbar_desc);
        end
        if (got.row_data !== exp.row_data) begin
            err_cnt++;
            $display("[ERROR] scpad_wr.row_data got %h expected %h",
                     got.row_data, exp.row_data);
        end
    endtask

    task automatic check_rsp(input sched_rsp_t got, input sched_rsp_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] sched_rsp got %h expected %h", got, exp);
        end
    endtask

    // one tile through the scheduler port
    task automatic run_tile(input int t);
        sched_req_t  req;
        sched_rsp_t  exp_rsp;
        dram_req_t   row_req;
        xbar_desc_t  row_desc;
        int unsigned err_before;
        int unsigned gap;
        logic        done;

        req.dram_addr  = dram_addr_t'($urandom) & 32'hffff_fff0;
        req.spad_addr  = slot_t'($urandom);
        req.num_rows   = dim_t'(1 + $urandom % `MAX_ROWS);
        req.num_cols   = dim_t'(1 + $urandom % `SCPAD_BANKS);
        req.row_or_col = 1'($urandom % 2);
        exp_rsp.spad_addr = req.spad_addr;
        exp_rsp.num_rows  = req.num_rows;
        // expected dram reads and descriptors per row
        for (int r = 0; r < int'(req.num_rows); r++) begin
            row_req.id         = model_uuid;
            row_req.dram_addr  = req.dram_addr + dram_addr_t'(r * `ROW_BYTES);
            row_req.num_bytes  = nbytes_t'(req.num_cols * 4);
            row_desc.slot      = req.spad_addr + slot_t'(r);
            row_desc.shift     = bank_t'(r % `SCPAD_BANKS);
            row_desc.col_mode  = req.row_or_col;
            row_desc.lane_mask = lane_mask_t'((1 << req.num_cols) - 1);
            exp_req_q.push_back(row_req);
            exp_desc_q.push_back(row_desc);
            model_uuid = model_uuid + dram_id_t'(1);
        end
        err_before  = err_cnt;
        tile_wr_cnt = 0;
        gap = $urandom % 4;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        sched_req_valid = 1'b1;
        sched_req       = req;
        do begin
            @(negedge clk);
        end while (!sched_req_ready);
        @(posedge clk);
        #1;
        sched_req_valid = 1'b0;
        // wait for the answer, random ready gaps
        done = 1'b0;
        while (!done) begin
            sched_rsp_ready = ($urandom % 3) != 0;
            @(negedge clk);
            if (sched_req_ready) begin
                report_fault("new scheduler request possible before the tile response");
            end
            if (sched_rsp_valid && sched_rsp_ready) begin
                check_rsp(sched_rsp, exp_rsp);
                if (tile_wr_cnt != int'(req.num_rows)) begin
                    report_fault($sformatf("tile %0d gave %0d scratchpad writes, not %0d",
                                           t, tile_wr_cnt, req.num_rows));
                end
                if (exp_req_q.size() != 0) begin
                    report_fault("tile response came before all DRAM reads were sent");
                end
                done = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        sched_rsp_ready = 1'b0;
        $display("tile %0d: %0d x %0d, %s mode, %s", t, req.num_rows, req.num_cols,
                 req.row_or_col ? "col" : "row", (err_cnt == err_before) ? "ok" : "errors");
    endtask

    initial begin : scheduler
        void'($urandom(32'hdf0a_8a15));
        n_rst           = 1'b0;
        sched_req_valid = 1'b0;
        sched_req       = '0;
        sched_rsp_ready = 1'b0;
        err_cnt         = 0;
        chk_cnt         = 0;
        tile_wr_cnt     = 0;
        model_uuid      = '0;
        repeat (8) @(posedge clk);
        #1;
        n_rst = 1'b1;
        // idle outputs straight out of reset
        @(negedge clk);
        check_flag("sched_req_ready", sched_req_ready, 1'b1);
        check_flag("sched_rsp_valid", sched_rsp_valid, 1'b0);
        check_flag("be_dram_req_valid", be_dram_req_valid, 1'b0);
        check_flag("scpad_wr_valid", scpad_wr_valid, 1'b0);
        @(posedge clk);
        #1;
        for (int t = 0; t < int'(NUM_TILES); t++) begin
            run_tile(t);
        end
        $display("tiles %0d, checks %0d, errors %0d", NUM_TILES, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // dram and scratchpad models, sample at negedge, drive after posedge
    initial begin : dram_scpad_model
        pend_t       ent;
        pend_t       cur;
        dram_req_t   exp_req;
        scpad_wr_t   exp_wr;
        logic        rsp_busy;
        int unsigned idx;
        int unsigned dram_stall;
        int unsigned spad_stall;

        be_dram_req_ready = 1'b0;
        dram_be_res_valid = 1'b0;
        dram_be_res       = '0;
        scpad_wr_ready    = 1'b0;
        rsp_busy   = 1'b0;
        dram_stall = 0;
        spad_stall = 0;
        cur        = '0;
        wait (n_rst === 1'b1);
        forever begin
            @(negedge clk);
            if (be_dram_req_valid && be_dram_req_ready) begin
                if (exp_req_q.size() == 0) begin
                    report_fault("DRAM read request with no row left in the tile");
                end else begin
                    exp_req = exp_req_q.pop_front();
                    check_req(be_dram_req, exp_req);
                    ent.id   = be_dram_req.id;
                    ent.addr = be_dram_req.dram_addr;
                    ent.desc = exp_desc_q.pop_front();
                    ent.due  = cycles + 2 + $urandom % 12;
                    pend_q.push_back(ent);
                end
            end
            if (!scpad_wr_ready && dram_be_res_ready) begin
                report_fault("DRAM response ready while the scratchpad stalls");
            end
            if (rsp_busy && dram_be_res_ready) begin
                exp_wr.xbar_desc = cur.desc;
                exp_wr.row_data  = dram_row(cur.addr);
                if (!(scpad_wr_valid && scpad_wr_ready)) begin
                    report_fault("DRAM response taken without a scratchpad write");
                end
                check_wr(scpad_wr, exp_wr);
                tile_wr_cnt++;
                rsp_busy = 1'b0;
            end
            @(posedge clk);
            #1;
            // random pick among due reads, so answers come out of order
            if (!rsp_busy) begin
                dram_be_res_valid = 1'b0;
                if (pend_q.size() != 0) begin
                    idx = $urandom % pend_q.size();
                    if (pend_q[idx].due <= cycles) begin
                        cur = pend_q[idx];
                        pend_q.delete(idx);
                        dram_be_res.id       = cur.id;
                        dram_be_res.row_data = dram_row(cur.addr);
                        dram_be_res_valid    = 1'b1;
                        rsp_busy             = 1'b1;
                    end
                end
            end
            // long dram stalls fill the request queue
            if (dram_stall != 0) begin
                dram_stall--;
                be_dram_req_ready = 1'b0;
            end else if ($urandom % 16 == 0) begin
                dram_stall = 10 + $urandom % 20;
                be_dram_req_ready = 1'b0;
            end else begin
                be_dram_req_ready = ($urandom % 4) != 0;
            end
            if (spad_stall != 0) begin
                spad_stall--;
                scpad_wr_ready = 1'b0;
            end else if ($urandom % 12 == 0) begin
                spad_stall = 5 + $urandom % 10;
                scpad_wr_ready = 1'b0;
            end else begin
                scpad_wr_ready = ($urandom % 3) != 0;
            end
        end
    end

endmodule

// File: tb.f
+incdir+.
scpad_pkg.sv
backend_ctrl.sv
addr_map.sv
dram_read_req_queue.sv
scpad_write_path.sv
backend.sv
backend_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module backend_tb -f tb.f -o backend_sim
./obj_dir/backend_sim | tee sim.log

if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "simulation reported failure, see sim.log"
exit 1
